// File: project.f
design/csu_pkg.sv
design/csu_decoder.sv
design/csr_file.sv
design/csu_pipe.sv
design/csu_top.sv
tb/csu_top_asserts.sv
tb/tb_csu_top.sv

// File: Bender.yml
package:
  name: csu

sources:
  - design/csu_pkg.sv
  - design/csu_decoder.sv
  - design/csr_file.sv
  - design/csu_pipe.sv
  - design/csu_top.sv
  - target: test
    files:
      - tb/csu_top_asserts.sv
      - tb/tb_csu_top.sv

// File: tb/tb_csu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csu_top
  import csu_pkg::*;
();

  localparam int    TAG_W   = 5;
  localparam xlen_t HART_ID = 32'h0000_0003;
  localparam int    N_TABLE = 26;
  localparam int    N_RAND  = 200;

  localparam logic [2:0] F_RW  = 3'd1;
  localparam logic [2:0] F_RS  = 3'd2;
  localparam logic [2:0] F_RC  = 3'd3;
  localparam logic [2:0] F_RWI = 3'd5;
  localparam logic [2:0] F_RSI = 3'd6;
  localparam logic [2:0] F_RCI = 3'd7;

  localparam xlen_t INST_ECALL   = 32'h0000_0073;
  localparam xlen_t INST_EBREAK  = 32'h0010_0073;
  localparam xlen_t INST_MRET    = 32'h3020_0073;
  localparam xlen_t INST_FENCE_I = 32'h0000_100F;

  logic             i_clk;
  logic             i_reset_n;
  logic             i_issue_valid;
  xlen_t            i_issue_inst;
  xlen_t            i_issue_rs1;
  logic [TAG_W-1:0] i_issue_tag;
  logic             i_issue_rd_en;
  priv_t            i_priv;
  logic             o_done_valid;
  logic [TAG_W-1:0] o_done_tag;
  except_t          o_done_except;
  xlen_t            o_done_tval;
  logic             o_rd_valid;
  xlen_t            o_rd_data;
  logic             o_fence_i;
  xlen_t            o_mepc;

  // Stimulus table
  int      tbl_test [N_TABLE];
  xlen_t   tbl_inst [N_TABLE];
  xlen_t   tbl_rs1  [N_TABLE];
  priv_t   tbl_priv [N_TABLE];
  except_t tbl_exc  [N_TABLE];
  xlen_t   tbl_data [N_TABLE];
  string   test_name [1:6];
  int      n_entries = 0;

  logic [TAG_W-1:0] exp_tag_q [$];
  except_t          exp_exc_q [$];
  xlen_t            exp_data_q [$];
  xlen_t            exp_tval_q [$];
  logic             exp_rd_en_q [$];

  priv_t            priv_line [3];  // i_priv reaches the slot in EX2
  logic [TAG_W-1:0] next_tag = '0;
  xlen_t            lfsr = 32'h14d0_ebc9;
  int               errors = 0;
  int               checks = 0;
  int               tests_passed = 0;

  csu_top #(
    .TAG_W   (TAG_W),
    .HART_ID (HART_ID)
  ) i_csu_top (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_issue_inst  (i_issue_inst),
    .i_issue_rs1   (i_issue_rs1),
    .i_issue_tag   (i_issue_tag),
    .i_issue_rd_en (i_issue_rd_en),
    .i_priv        (i_priv),
    .o_done_valid  (o_done_valid),
    .o_done_tag    (o_done_tag),
    .o_done_except (o_done_except),
    .o_done_tval   (o_done_tval),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .o_fence_i     (o_fence_i),
    .o_mepc        (o_mepc)
  );

  bind csu_top csu_top_asserts #(.TAG_W(TAG_W)) u_csu_top_asserts (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_done_valid  (o_done_valid),
    .i_done_tag    (o_done_tag),
    .i_done_except (o_done_except),
    .i_done_tval   (o_done_tval),
    .i_rd_valid    (o_rd_valid),
    .i_rd_data     (o_rd_data),
    .i_fence_i     (o_fence_i)
  );

  always #5 i_clk = ~i_clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic xlen_t csr_inst(input logic [2:0] f3, input csr_addr_t addr,
                                     input logic [4:0] src);
    return {addr, src, f3, 5'd10, 7'b1110011};
  endfunction

  function automatic xlen_t lfsr_next(input xlen_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output xlen_t v);
    int b;
    v = '0;
    for (b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[XLEN-2:0], lfsr[0]};  // One step per bit
    end
  endtask

  task automatic add_entry(input int t, input xlen_t inst, input xlen_t rs1,
                           input priv_t priv, input except_t exc, input xlen_t data);
    tbl_test[n_entries] = t;
    tbl_inst[n_entries] = inst;
    tbl_rs1[n_entries]  = rs1;
    tbl_priv[n_entries] = priv;
    tbl_exc[n_entries]  = exc;
    tbl_data[n_entries] = data;
    n_entries++;
  endtask

  task automatic check_except(input string name, input except_t got, input except_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic rd_en, input xlen_t inst,
                             input xlen_t rs1, input priv_t priv);
    @(negedge i_clk);
    i_issue_valid = valid;
    i_issue_inst  = inst;
    i_issue_rs1   = rs1;
    i_issue_tag   = next_tag;
    i_issue_rd_en = valid & rd_en;
    i_priv        = priv_line[2];
    priv_line[2]  = priv_line[1];
    priv_line[1]  = priv_line[0];
    priv_line[0]  = priv;
    if (valid) begin
      next_tag = next_tag + 1'b1;
    end
  endtask

  task automatic issue_slot(input xlen_t inst, input xlen_t rs1, input logic rd_en,
                            input priv_t priv, input except_t exc, input xlen_t data);
    drive_cycle(1'b1, rd_en, inst, rs1, priv);
    exp_tag_q.push_back(i_issue_tag);
    exp_exc_q.push_back(exc);
    exp_data_q.push_back(data);
    exp_tval_q.push_back((exc == EXC_ILLEGAL) ? inst : '0);
    exp_rd_en_q.push_back(rd_en);
  endtask

  task automatic drain();
    while (exp_tag_q.size() != 0) begin
      drive_cycle(1'b0, 1'b0, '0, '0, PRIV_M);
    end
  endtask

  task automatic report_test(input int t, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("test %0d %s: ok", t, test_name[t]);
    end else begin
      $display("test %0d %s: %0d errors", t, test_name[t], errors - err_start);
    end
  endtask

  task automatic build_table();
    test_name[1] = "mscratch write/set/clear back to back";
    test_name[2] = "mhartid and unknown address";
    test_name[3] = "privilege, ECALL, MRET, EBREAK";
    test_name[4] = "mepc, mtvec, mstatus masks";
    test_name[5] = "FENCE.I and immediate forms";
    test_name[6] = "random mscratch traffic";
    add_entry(1, csr_inst(F_RW, CSR_MSCRATCH, 5'd5), 32'hA5A5_0F0F, PRIV_M, EXC_SILENT_FLUSH, 0);
    add_entry(1, csr_inst(F_RS, CSR_MSCRATCH, 5'd5), 32'h0000_F0F0, PRIV_M, EXC_SILENT_FLUSH,
              32'hA5A5_0F0F);
    add_entry(1, csr_inst(F_RC, CSR_MSCRATCH, 5'd5), 32'hA500_00FF, PRIV_M, EXC_SILENT_FLUSH,
              32'hA5A5_FFFF);
    add_entry(1, csr_inst(F_RS, CSR_MSCRATCH, 5'd0), '0, PRIV_M, EXC_NONE, 32'h00A5_FF00);
    add_entry(2, csr_inst(F_RS, CSR_MHARTID, 5'd0), '0, PRIV_M, EXC_NONE, HART_ID);
    add_entry(2, csr_inst(F_RW, CSR_MHARTID, 5'd5), 32'h1234, PRIV_M, EXC_ILLEGAL, '0);
    add_entry(2, csr_inst(F_RS, 12'h7C0, 5'd0), '0, PRIV_M, EXC_ILLEGAL, '0);
    add_entry(3, csr_inst(F_RS, CSR_MSTATUS, 5'd0), '0, PRIV_U, EXC_ILLEGAL, '0);
    add_entry(3, csr_inst(F_RS, CSR_MSTATUS, 5'd0), '0, PRIV_S, EXC_ILLEGAL, '0);
    add_entry(3, INST_ECALL, '0, PRIV_U, EXC_ECALL_U, '0);
    add_entry(3, INST_ECALL, '0, PRIV_S, EXC_ECALL_S, '0);
    add_entry(3, INST_ECALL, '0, PRIV_M, EXC_ECALL_M, '0);
    add_entry(3, INST_MRET, '0, PRIV_U, EXC_ILLEGAL, '0);
    add_entry(3, INST_MRET, '0, PRIV_S, EXC_ILLEGAL, '0);
    add_entry(3, INST_MRET, '0, PRIV_M, EXC_MRET, '0);
    add_entry(3, INST_EBREAK, '0, PRIV_S, EXC_BREAKPOINT, '0);
    add_entry(4, csr_inst(F_RW, CSR_MEPC, 5'd5), 32'h8000_1237, PRIV_M, EXC_SILENT_FLUSH, '0);
    add_entry(4, csr_inst(F_RW, CSR_MTVEC, 5'd5), 32'h0000_4103, PRIV_M, EXC_SILENT_FLUSH, '0);
    add_entry(4, csr_inst(F_RS, CSR_MEPC, 5'd0), '0, PRIV_M, EXC_NONE, 32'h8000_1234);
    add_entry(4, csr_inst(F_RS, CSR_MTVEC, 5'd0), '0, PRIV_M, EXC_NONE, 32'h0000_4100);
    add_entry(4, csr_inst(F_RW, CSR_MSTATUS, 5'd5), 32'hFFFF_FFFF, PRIV_M, EXC_SILENT_FLUSH, '0);
    add_entry(4, csr_inst(F_RC, CSR_MSTATUS, 5'd0), '0, PRIV_M, EXC_NONE, 32'h0000_0088);
    add_entry(5, INST_FENCE_I, '0, PRIV_M, EXC_FENCE_I, '0);
    // rs1 value must be ignored by the immediate forms
    add_entry(5, csr_inst(F_RWI, CSR_MSCRATCH, 5'h1F), 32'hDEAD_BEEF, PRIV_M, EXC_SILENT_FLUSH,
              32'h00A5_FF00);
    add_entry(5, csr_inst(F_RCI, CSR_MSCRATCH, 5'h05), 32'hFFFF_FFFF, PRIV_M, EXC_SILENT_FLUSH,
              32'h0000_001F);
    add_entry(5, csr_inst(F_RSI, CSR_MSCRATCH, 5'h00), 32'hFFFF_FFFF, PRIV_M, EXC_NONE,
              32'h0000_001A);
  endtask

  // ----------------------------------------
  // Completion checker
  // ----------------------------------------
  always @(negedge i_clk) begin : completion_monitor
    except_t exc;
    logic    rd_exp;
    xlen_t   data_exp;
    if (i_reset_n && o_done_valid) begin
      if (exp_tag_q.size() == 0) begin
        errors++;
        $display("[ERROR] %0t ns: completion arrived with no slot outstanding", $time);
      end else begin
        exc      = exp_exc_q.pop_front();
        data_exp = exp_data_q.pop_front();
        rd_exp   = exp_rd_en_q.pop_front() &&
                   ((exc == EXC_NONE) || (exc == EXC_SILENT_FLUSH));
        check_data("o_done_tag", xlen_t'(o_done_tag), xlen_t'(exp_tag_q.pop_front()));
        check_except("o_done_except", o_done_except, exc);
        check_data("o_done_tval", o_done_tval, exp_tval_q.pop_front());
        check_flag("o_rd_valid", o_rd_valid, rd_exp);
        check_flag("o_fence_i", o_fence_i, exc == EXC_FENCE_I);
        if (rd_exp) begin
          check_data("o_rd_data", o_rd_data, data_exp);
        end
      end
    end
  end

  initial begin : watchdog
    #((N_TABLE + N_RAND + 50) * 10);
    $display("timeout: completions still outstanding at %0t ns", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    int       t;
    int       j;
    int       err_start;
    xlen_t    shadow;
    xlen_t    r_op;
    xlen_t    r_idx;
    xlen_t    r_data;
    xlen_t    r_rd;
    xlen_t    src;
    logic [2:0] f3;
    logic     wr;
    i_clk         = 1'b0;
    i_reset_n     = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_inst  = '0;
    i_issue_rs1   = '0;
    i_issue_tag   = '0;
    i_issue_rd_en = 1'b0;
    i_priv        = PRIV_M;
    priv_line     = '{PRIV_M, PRIV_M, PRIV_M};
    build_table();
    repeat (8) @(negedge i_clk);
    i_reset_n = 1'b1;
    check_flag("o_done_valid", o_done_valid, 1'b0);
    check_flag("o_rd_valid", o_rd_valid, 1'b0);
    check_flag("o_fence_i", o_fence_i, 1'b0);

    for (t = 1; t <= 5; t++) begin
      err_start = errors;
      for (j = 0; j < N_TABLE; j++) begin
        if (tbl_test[j] == t) begin
          issue_slot(tbl_inst[j], tbl_rs1[j], 1'b1, tbl_priv[j], tbl_exc[j], tbl_data[j]);
        end
      end
      drain();
      if (t == 4) begin
        check_data("o_mepc", o_mepc, 32'h8000_1234);
      end
      report_test(t, err_start);
    end

    // Shadow mscratch starts from the value left by test 5
    err_start = errors;
    shadow    = 32'h0000_001A;
    for (j = 0; j < N_RAND; j++) begin
      rand_bits(2, r_op);
      rand_bits(5, r_idx);
      rand_bits(32, r_data);
      rand_bits(1, r_rd);
      f3  = (r_op[1:0] == 2'd1) ? F_RS : (r_op[1:0] == 2'd2) ? F_RC : F_RW;
      src = (r_idx[4:0] == 5'd0) ? '0 : r_data;
      wr  = (f3 == F_RW) || (r_idx[4:0] != 5'd0);
      issue_slot(csr_inst(f3, CSR_MSCRATCH, r_idx[4:0]), src, r_rd[0], PRIV_M,
                 wr ? EXC_SILENT_FLUSH : EXC_NONE, shadow);
      if (wr) begin
        shadow = (f3 == F_RS) ? (shadow | src) : (f3 == F_RC) ? (shadow & ~src) : src;
      end
    end
    drain();
    report_test(6, err_start);

    $display("summary: %0d of 6 tests ok, %0d checks, %0d errors", tests_passed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/csu_top_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csu_top_asserts
  import csu_pkg::*;
#(
  parameter int TAG_W = 5
) (
  input wire logic        i_clk,
  input wire logic        i_reset_n,
  input logic             i_issue_valid,
  input logic             i_done_valid,
  input logic [TAG_W-1:0] i_done_tag,
  input except_t          i_done_except,
  input xlen_t            i_done_tval,
  input logic             i_rd_valid,
  input xlen_t            i_rd_data,
  input logic             i_fence_i
);

  // Fixed three-cycle latency, seen one edge later by the sampled done flag
  a_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid == $past(i_issue_valid, 4))
    else $error("completion does not follow its issue by three cycles");

  a_side_flags: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_rd_valid || i_fence_i) |-> i_done_valid)
    else $error("rd or fence flag raised without a completion");

  a_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown({i_done_valid, i_done_tag, i_done_except, i_done_tval,
                 i_rd_valid, i_rd_data, i_fence_i}))
    else $error("completion outputs unknown after reset");

endmodule

`default_nettype wire

// File: design/csu_top.sv
`timescale 1ns/10ps
`default_nettype none

module csu_top
  import csu_pkg::*;
#(
  parameter int    TAG_W   = 5,
  parameter xlen_t HART_ID = 32'h0
) (
  input  wire logic        i_clk,
  input  wire logic        i_reset_n,

  input  logic             i_issue_valid,
  input  xlen_t            i_issue_inst,
  input  xlen_t            i_issue_rs1,
  input  logic [TAG_W-1:0] i_issue_tag,
  input  logic             i_issue_rd_en,
  input  priv_t            i_priv,

  output logic             o_done_valid,
  output logic [TAG_W-1:0] o_done_tag,
  output except_t          o_done_except,
  output xlen_t            o_done_tval,
  output logic             o_rd_valid,
  output xlen_t            o_rd_data,
  output logic             o_fence_i,
  output xlen_t            o_mepc
);

  xlen_t     w_dec_inst;
  csu_op_t   w_dec_op;
  logic      w_dec_imm;

  logic      w_csr_rd_en;
  csr_addr_t w_csr_addr;
  logic      w_csr_wr_intent;
  logic      w_csr_wr_en;
  xlen_t     w_csr_wr_data;
  xlen_t     w_csr_rd_data;
  logic      w_csr_error;

  csu_decoder u_csu_decoder (
    .i_inst (w_dec_inst),
    .o_op   (w_dec_op),
    .o_imm  (w_dec_imm)
  );

  csr_file #(
    .HART_ID (HART_ID)
  ) u_csr_file (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd_en     (w_csr_rd_en),
    .i_addr      (w_csr_addr),
    .i_priv      (i_priv),
    .i_wr_intent (w_csr_wr_intent),
    .o_rd_data   (w_csr_rd_data),
    .o_error     (w_csr_error),
    .i_wr_en     (w_csr_wr_en),
    .i_wr_data   (w_csr_wr_data),
    .o_mepc      (o_mepc)
  );

  csu_pipe #(
    .TAG_W (TAG_W)
  ) u_csu_pipe (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_issue_valid   (i_issue_valid),
    .i_issue_inst    (i_issue_inst),
    .i_issue_rs1     (i_issue_rs1),
    .i_issue_tag     (i_issue_tag),
    .i_issue_rd_en   (i_issue_rd_en),
    .i_priv          (i_priv),
    .o_dec_inst      (w_dec_inst),
    .i_dec_op        (w_dec_op),
    .i_dec_imm       (w_dec_imm),
    .o_csr_rd_en     (w_csr_rd_en),
    .o_csr_addr      (w_csr_addr),
    .o_csr_wr_intent (w_csr_wr_intent),
    .o_csr_wr_en     (w_csr_wr_en),
    .o_csr_wr_data   (w_csr_wr_data),
    .i_csr_rd_data   (w_csr_rd_data),
    .i_csr_error     (w_csr_error),
    .o_done_valid    (o_done_valid),
    .o_done_tag      (o_done_tag),
    .o_done_except   (o_done_except),
    .o_done_tval     (o_done_tval),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_fence_i       (o_fence_i)
  );

endmodule

`default_nettype wire

// File: design/csu_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module csu_pipe
  import csu_pkg::*;
#(
  parameter int TAG_W = 5
) (
  input  wire logic        i_clk,
  input  wire logic        i_reset_n,

  input  logic             i_issue_valid,
  input  xlen_t            i_issue_inst,
  input  xlen_t            i_issue_rs1,
  input  logic [TAG_W-1:0] i_issue_tag,
  input  logic             i_issue_rd_en,
  input  priv_t            i_priv,

  output xlen_t            o_dec_inst,
  input  csu_op_t          i_dec_op,
  input  logic             i_dec_imm,

  output logic             o_csr_rd_en,
  output csr_addr_t        o_csr_addr,
  output logic             o_csr_wr_intent,
  output logic             o_csr_wr_en,
  output xlen_t            o_csr_wr_data,
  input  xlen_t            i_csr_rd_data,
  input  logic             i_csr_error,

  output logic             o_done_valid,
  output logic [TAG_W-1:0] o_done_tag,
  output except_t          o_done_except,
  output xlen_t            o_done_tval,
  output logic             o_rd_valid,
  output xlen_t            o_rd_data,
  output logic             o_fence_i
);

  logic             r_ex0_valid;
  xlen_t            r_ex0_inst;
  xlen_t            r_ex0_rs1;
  logic [TAG_W-1:0] r_ex0_tag;
  logic             r_ex0_rd_en;

  logic             r_ex1_valid;
  csu_op_t          r_ex1_op;
  logic             r_ex1_imm;
  xlen_t            r_ex1_inst;
  xlen_t            r_ex1_rs1;
  logic [TAG_W-1:0] r_ex1_tag;
  logic             r_ex1_rd_en;

  logic             r_ex2_valid;
  csu_op_t          r_ex2_op;
  xlen_t            r_ex2_inst;
  xlen_t            r_ex2_src;
  logic [TAG_W-1:0] r_ex2_tag;
  logic             r_ex2_rd_en;

  logic             w_ex2_is_csr;
  logic             w_ex2_access;
  logic             w_ex2_wr_intent;
  xlen_t            w_ex2_new_data;
  except_t          w_ex2_except;

  logic             r_ex3_valid;
  logic [TAG_W-1:0] r_ex3_tag;
  except_t          r_ex3_except;
  xlen_t            r_ex3_tval;
  logic             r_ex3_rd_valid;
  xlen_t            r_ex3_rd_data;
  logic             r_ex3_fence_i;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid <= 1'b0;
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex0_valid <= i_issue_valid;
      r_ex1_valid <= r_ex0_valid;
      r_ex2_valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_inst  <= i_issue_inst;
    r_ex0_rs1   <= i_issue_rs1;
    r_ex0_tag   <= i_issue_tag;
    r_ex0_rd_en <= i_issue_rd_en;

    r_ex1_op    <= i_dec_op;  // Decoded from the EX0 instruction
    r_ex1_imm   <= i_dec_imm;
    r_ex1_inst  <= r_ex0_inst;
    r_ex1_rs1   <= r_ex0_rs1;
    r_ex1_tag   <= r_ex0_tag;
    r_ex1_rd_en <= r_ex0_rd_en;

    r_ex2_op    <= r_ex1_op;
    r_ex2_inst  <= r_ex1_inst;
    r_ex2_src   <= r_ex1_imm ? {{(XLEN-5){1'b0}}, r_ex1_inst[19:15]} : r_ex1_rs1;
    r_ex2_tag   <= r_ex1_tag;
    r_ex2_rd_en <= r_ex1_rd_en;
  end

  assign o_dec_inst = r_ex0_inst;

  // ----------------------------------------
  // EX2 CSR read-modify-write
  // ----------------------------------------
  assign w_ex2_is_csr    = (r_ex2_op == OP_RW) || (r_ex2_op == OP_RS) || (r_ex2_op == OP_RC);
  assign w_ex2_access    = r_ex2_valid & w_ex2_is_csr;
  // Set or clear with x0 / zero uimm is a pure read
  assign w_ex2_wr_intent = (r_ex2_op == OP_RW) |
                           (w_ex2_is_csr & (r_ex2_inst[19:15] != 5'd0));

  always_comb begin
    case (r_ex2_op)
      OP_RS:   w_ex2_new_data = i_csr_rd_data | r_ex2_src;
      OP_RC:   w_ex2_new_data = i_csr_rd_data & ~r_ex2_src;
      default: w_ex2_new_data = r_ex2_src;
    endcase
  end

  assign o_csr_rd_en     = w_ex2_access;
  assign o_csr_addr      = r_ex2_inst[31:20];
  assign o_csr_wr_intent = w_ex2_wr_intent;
  assign o_csr_wr_en     = w_ex2_access & w_ex2_wr_intent & ~i_csr_error;
  assign o_csr_wr_data   = w_ex2_new_data;

  always_comb begin
    case (r_ex2_op)
      OP_RW, OP_RS, OP_RC: begin
        if (i_csr_error) begin
          w_ex2_except = EXC_ILLEGAL;
        end else if (w_ex2_wr_intent) begin
          w_ex2_except = EXC_SILENT_FLUSH;
        end else begin
          w_ex2_except = EXC_NONE;
        end
      end
      OP_ECALL: begin
        case (i_priv)
          PRIV_U:  w_ex2_except = EXC_ECALL_U;
          PRIV_S:  w_ex2_except = EXC_ECALL_S;
          default: w_ex2_except = EXC_ECALL_M;
        endcase
      end
      OP_EBREAK:  w_ex2_except = EXC_BREAKPOINT;
      OP_MRET:    w_ex2_except = (i_priv == PRIV_M) ? EXC_MRET : EXC_ILLEGAL;
      OP_FENCE_I: w_ex2_except = EXC_FENCE_I;
      default:    w_ex2_except = EXC_ILLEGAL;  // Unknown encoding
    endcase
  end

  // ----------------------------------------
  // EX3 completion
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid    <= 1'b0;
      r_ex3_tag      <= '0;
      r_ex3_except   <= EXC_NONE;
      r_ex3_tval     <= '0;
      r_ex3_rd_valid <= 1'b0;
      r_ex3_rd_data  <= '0;
      r_ex3_fence_i  <= 1'b0;
    end else begin
      r_ex3_valid    <= r_ex2_valid;
      r_ex3_tag      <= r_ex2_tag;
      r_ex3_except   <= w_ex2_except;
      r_ex3_tval     <= (w_ex2_except == EXC_ILLEGAL) ? r_ex2_inst : '0;
      r_ex3_rd_valid <= w_ex2_access & r_ex2_rd_en & ~i_csr_error;
      r_ex3_rd_data  <= i_csr_rd_data;  // Old value
      r_ex3_fence_i  <= r_ex2_valid & (r_ex2_op == OP_FENCE_I);
    end
  end

  assign o_done_valid  = r_ex3_valid;
  assign o_done_tag    = r_ex3_tag;
  assign o_done_except = r_ex3_except;
  assign o_done_tval   = r_ex3_tval;
  assign o_rd_valid    = r_ex3_rd_valid;
  assign o_rd_data     = r_ex3_rd_data;
  assign o_fence_i     = r_ex3_fence_i;

endmodule

`default_nettype wire

// File: design/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file
  import csu_pkg::*;
#(
  parameter xlen_t HART_ID = 32'h0
) (
  input  wire logic i_clk,
  input  wire logic i_reset_n,

  input  logic      i_rd_en,
  input  csr_addr_t i_addr,
  input  priv_t     i_priv,
  input  logic      i_wr_intent,
  output xlen_t     o_rd_data,
  output logic      o_error,

  input  logic      i_wr_en,
  input  xlen_t     i_wr_data,

  output xlen_t     o_mepc
);

  localparam xlen_t MSTATUS_MASK = 32'h0000_0088;  // MPIE and MIE

  xlen_t r_mstatus;
  xlen_t r_mtvec;
  xlen_t r_mscratch;
  xlen_t r_mepc;
  xlen_t r_mcause;

  xlen_t w_rd_data;
  logic  w_known;
  logic  w_priv_low;
  logic  w_read_only;

  // ----------------------------------------
  // Address decode and read mux
  // ----------------------------------------
  always_comb begin
    w_known = 1'b1;
    case (i_addr)
      CSR_MSTATUS:  w_rd_data = r_mstatus;
      CSR_MTVEC:    w_rd_data = r_mtvec;
      CSR_MSCRATCH: w_rd_data = r_mscratch;
      CSR_MEPC:     w_rd_data = r_mepc;
      CSR_MCAUSE:   w_rd_data = r_mcause;
      CSR_MHARTID:  w_rd_data = HART_ID;
      default: begin
        w_known   = 1'b0;
        w_rd_data = '0;
      end
    endcase
  end

  assign w_priv_low  = 2'(i_priv) < i_addr[9:8];
  assign w_read_only = (i_addr[11:10] == 2'b11);

  assign o_error   = i_rd_en & (!w_known | w_priv_low | (i_wr_intent & w_read_only));
  assign o_rd_data = w_rd_data;

  // ----------------------------------------
  // Write port, masked per register
  // ----------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mtvec    <= '0;
      r_mscratch <= '0;
      r_mepc     <= '0;
      r_mcause   <= '0;
    end else if (i_wr_en) begin
      case (i_addr)
        CSR_MSTATUS:  r_mstatus  <= i_wr_data & MSTATUS_MASK;
        CSR_MTVEC:    r_mtvec    <= {i_wr_data[XLEN-1:2], 2'b00};  // Direct mode only
        CSR_MSCRATCH: r_mscratch <= i_wr_data;
        CSR_MEPC:     r_mepc     <= {i_wr_data[XLEN-1:2], 2'b00};
        CSR_MCAUSE:   r_mcause   <= i_wr_data;
        default: ;
      endcase
    end
  end

  assign o_mepc = r_mepc;

endmodule

`default_nettype wire

// File: design/csu_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module csu_decoder
  import csu_pkg::*;
(
  input  xlen_t   i_inst,
  output csu_op_t o_op,
  output logic    o_imm
);

  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

  logic [6:0]  w_opcode;
  logic [2:0]  w_funct3;
  logic [11:0] w_funct12;
  logic        w_regs_zero;

  assign w_opcode    = i_inst[6:0];
  assign w_funct3    = i_inst[14:12];
  assign w_funct12   = i_inst[31:20];
  assign w_regs_zero = (i_inst[19:15] == 5'd0) && (i_inst[11:7] == 5'd0);

  always_comb begin
    o_op  = OP_NONE;
    o_imm = 1'b0;
    if (w_opcode == OPC_SYSTEM) begin
      case (w_funct3)
        3'b000: begin
          // PRIV group, rs1 and rd must be x0
          if (w_regs_zero) begin
            case (w_funct12)
              12'h000: o_op = OP_ECALL;
              12'h001: o_op = OP_EBREAK;
              12'h302: o_op = OP_MRET;
              default: o_op = OP_NONE;
            endcase
          end
        end
        3'b001, 3'b101: o_op = OP_RW;
        3'b010, 3'b110: o_op = OP_RS;
        3'b011, 3'b111: o_op = OP_RC;
        default:        o_op = OP_NONE;
      endcase
      o_imm = w_funct3[2] & (w_funct3[1:0] != 2'b00);  // CSRR*I
    end else if ((w_opcode == OPC_MISC_MEM) && (w_funct3 == 3'b001)) begin
      o_op = OP_FENCE_I;
    end
  end

endmodule

`default_nettype wire

// File: design/csu_pkg.sv
`default_nettype none

package csu_pkg;

  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // Machine-mode CSR map
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11  // Encodings match the spec privilege field
  } priv_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC,
    OP_ECALL,
    OP_EBREAK,
    OP_MRET,
    OP_FENCE_I
  } csu_op_t;

  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_SILENT_FLUSH,  // Legal CSR write, younger ops refetched
    EXC_ILLEGAL,
    EXC_ECALL_U,
    EXC_ECALL_S,
    EXC_ECALL_M,
    EXC_BREAKPOINT,
    EXC_MRET,
    EXC_FENCE_I
  } except_t;

endpackage

`default_nettype wire
